// ==== fmaPkg.sv ====
// binary16 only; finite operands assumed, subnormals flush to zero, no flags, one rounding mode
`default_nettype none

package fmaPkg;

  ////////////////////
  // format constants
  ////////////////////
  localparam int fmtNE = 5;
  localparam int fmtNF = 10;
  localparam int fmtBias = 15;
  localparam int fmtW = 16;
  // largest biased exponent of a finite result
  localparam int fmtEMax = 2**fmtNE - 2;

  // datapath widths
  localparam int amW = 3*fmtNF + 6;    // aligned addend and sum
  localparam int pmW = 2*fmtNF + 2;    // significand product
  localparam int expW = fmtNE + 2;     // signed biased exponents
  localparam int lzcW = $clog2(amW);   // leading-zero count

  // one binary16 word split into its fields
  typedef struct packed {
    logic             sign;
    logic [fmtNE-1:0] expo;
    logic [fmtNF-1:0] frac;
  } fpWordT;

  ////////////////////
  // stage payloads
  ////////////////////

  // request into stage 1, computes x*y+z
  typedef struct packed {
    logic [fmtW-1:0] x;
    logic [fmtW-1:0] y;
    logic [fmtW-1:0] z;
  } fmaOperandT;

  // stage 1 to stage 2
  typedef struct packed {
    logic [amW-1:0]          am;        // aligned addend
    logic [pmW-1:0]          pm;        // product significand
    logic signed [expW-1:0]  pe;        // product exponent, biased
    logic [fmtNE-1:0]        ze;        // addend exponent
    logic                    ps;        // product sign
    logic                    invA;      // effective subtraction
    logic                    killProd;  // product below the addend's reach
    logic                    aSticky;   // addend bits lost in alignment
  } fmaAlignT;

  // stage 2 to stage 3, sm is always non-negative
  typedef struct packed {
    logic [amW-1:0]          sm;
    logic                    ss;
    logic signed [expW-1:0]  se;
  } fmaSumT;

  // rounded result
  typedef struct packed {
    logic [fmtW-1:0] word;
  } fmaResultT;

endpackage

`default_nettype wire

// ==== fmaStageReg.sv ====
// single-entry stream register; full throughput relies on outReady reaching inReady in the same cycle
`timescale 1ns/1ps
`default_nettype none

module fmaStageReg import fmaPkg::*; #(
  parameter type payloadT = fmaResultT
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  logic    full;
  payloadT dataQ;

  // take a new item when empty or when the held one leaves this cycle
  assign inReady = !full || outReady;

  // occupancy follows the upstream valid whenever a slot is offered
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      full <= 1'b0;
    end else if (inReady) begin
      full <= inValid;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge clk) begin
    if (inReady && inValid) begin
      dataQ <= inData;
    end
  end

  assign outValid = full;
  assign outData  = dataQ;

  // a stalled item must stay put and stay offered until the consumer takes it
  stallHold: assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outData))
    else $error("stage register dropped or changed a stalled item");

endmodule

`default_nettype wire

// ==== fmaMulAlign.sv ====
// stage 1, combinational; exponent field zero reads as zero, NaN and infinity codes are not decoded
`timescale 1ns/1ps
`default_nettype none

module fmaMulAlign import fmaPkg::*; (
  input  fmaOperandT op,
  output fmaAlignT   align
);

  fpWordT                 xw;
  fpWordT                 yw;
  fpWordT                 zw;
  logic                   xZero;
  logic                   yZero;
  logic                   zZero;
  logic [fmtNF:0]         xm;
  logic [fmtNF:0]         ym;
  logic [fmtNF:0]         zm;
  logic                   ps;
  logic [pmW-1:0]         pm;
  logic signed [expW-1:0] pe;
  logic signed [expW-1:0] aCnt;
  logic [2*amW-1:0]       zShift;
  logic                   killProd;
  logic [amW-1:0]         am;
  logic                   aSticky;

  ////////////////////
  // unpack and flush
  ////////////////////
  assign xw = fpWordT'(op.x);
  assign yw = fpWordT'(op.y);
  assign zw = fpWordT'(op.z);

  // zero exponent field covers true zeros and subnormals alike
  assign xZero = (xw.expo == '0);
  assign yZero = (yw.expo == '0);
  assign zZero = (zw.expo == '0);

  // hidden one restored, flushed operands become all zero
  assign xm = xZero ? '0 : {1'b1, xw.frac};
  assign ym = yZero ? '0 : {1'b1, yw.frac};
  assign zm = zZero ? '0 : {1'b1, zw.frac};

  ////////////////////
  // product
  ////////////////////
  assign ps = xw.sign ^ yw.sign;
  // 1.10 x 1.10 gives a 2.20 product
  assign pm = xm * ym;
  assign pe = {2'b00, xw.expo} + {2'b00, yw.expo} - expW'(fmtBias);

  ////////////////////
  // addend alignment
  ////////////////////
  // unshifted addend sits NF+3 above the product's units bit
  // so a shift of pe-ze+NF+3 lines the two up
  assign aCnt = pe - {2'b00, zw.expo} + expW'(fmtNF + 3);

  // double width keeps everything shifted off the bottom for the sticky
  assign zShift = {zm, {(2*amW - fmtNF - 1){1'b0}}} >> aCnt;

  // negative count means the addend sits above the whole product
  assign killProd = (aCnt[expW-1] && !zZero) || xZero || yZero;

  always_comb begin
    if (killProd) begin
      // addend's leading one parked on the product's units bit
      am      = {{(fmtNF+3){1'b0}}, zm, {(fmtNF+2){1'b0}}};
      // a nonzero product was thrown away
      aSticky = !(xZero || yZero);
    end else begin
      am      = zShift[2*amW-1:amW];
      aSticky = |zShift[amW-1:0];
    end
  end

  assign align.am       = am;
  assign align.pm       = pm;
  assign align.pe       = pe;
  assign align.ze       = zw.expo;
  assign align.ps       = ps;
  // signs differ, so the addend gets subtracted
  assign align.invA     = ps ^ zw.sign;
  assign align.killProd = killProd;
  assign align.aSticky  = aSticky;

endmodule

`default_nettype wire

// ==== fmaSigAdd.sv ====
// stage 2, combinational; needs the product and addend placement produced by fmaMulAlign
`timescale 1ns/1ps
`default_nettype none

module fmaSigAdd import fmaPkg::*; (
  input  fmaAlignT align,
  output fmaSumT   sum
);

  logic [amW-1:0] amInv;
  logic [pmW-1:0] pmKilled;
  logic [amW-1:0] preSum;
  logic [amW-1:0] negPreSum;
  logic [amW-1:0] selSum;
  logic           negSum;

  ////////////////////
  // operand prep
  ////////////////////
  // ones' complement here, the +1 comes in through the adder below
  assign amInv    = align.invA ? ~align.am : align.am;
  assign pmKilled = align.killProd ? '0 : align.pm;

  ////////////////////
  // dual sum
  ////////////////////
  // product minus addend, the carry bit doubles as the sign
  // with addend bits lost to sticky the true value sits just under this,
  // so the +1 of the negation is skipped and the floor is kept
  assign {negSum, preSum} = {{(fmtNF+3){1'b0}}, pmKilled, 2'b00}
                          + {align.invA, amInv}
                          + {{amW{1'b0}}, (~align.aSticky | align.killProd) & align.invA};

  // addend minus product, formed in parallel
  // a killed nonzero product drops one unit at bit 2, the floor of the exact value
  assign negPreSum = align.am
                   + {{(fmtNF+2){1'b1}}, ~pmKilled, 2'b00}
                   + {{(amW-3){1'b0}}, ~align.aSticky | ~align.killProd, 2'b00};

  // keep whichever one is non-negative
  assign selSum = negSum ? negPreSum : preSum;

  // lost bits always land below the guard position, so jam them into bit 0
  assign sum.sm = {selSum[amW-1:1], selSum[0] | align.aSticky};
  // -p+z and p-z flip sign together with negSum
  assign sum.ss = negSum ^ align.ps;
  // killed product means the addend carries the exponent
  assign sum.se = align.killProd ? $signed({2'b00, align.ze}) : align.pe;

  // a killed product only happens against a nonzero addend, so a pure add cannot cancel
  always_comb begin
    killNoCancel: assert final (!(align.killProd && !align.invA && align.pm != '0
                                  && selSum == '0))
      else $error("killed product with nonzero pm gave a zero sum");
  end

endmodule

`default_nettype wire

// ==== fmaNormRound.sv ====
// combinational with nearest-even rounding only; underflow gives signed zero, overflow infinity
`timescale 1ns/1ps
`default_nettype none

module fmaNormRound import fmaPkg::*; (
  input  fmaSumT    sum,
  output fmaResultT res
);

  logic [lzcW-1:0]      lzc;
  logic [amW-1:0]       normSm;
  logic [fmtNF:0]       sig;
  logic                 guard;
  logic                 sticky;
  logic                 roundUp;
  logic [fmtNF+1:0]     sigRnd;
  logic signed [expW:0] normE;
  logic signed [expW:0] rndE;
  logic                 sumZero;

  ////////////////////
  // normalize
  ////////////////////
  // leading-zero count where the highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < amW; i++) begin
      if (sum.sm[i]) begin
        lzc = lzcW'(amW - 1 - i);
      end
    end
  end

  assign sumZero = (sum.sm == '0);

  // leading one to the top
  assign normSm = sum.sm << lzc;

  // units bit of se sits NF+3 below the top bit
  assign normE = {sum.se[expW-1], sum.se} + (expW+1)'(fmtNF + 3)
               - {{(expW+1-lzcW){1'b0}}, lzc};

  ////////////////////
  // round
  ////////////////////
  assign sig    = normSm[amW-1 -: fmtNF+1];
  assign guard  = normSm[amW-fmtNF-2];
  assign sticky = |normSm[amW-fmtNF-3:0];

  // round to nearest with ties to the even neighbour
  assign roundUp = guard && (sticky || sig[0]);
  assign sigRnd  = {1'b0, sig} + (fmtNF+2)'(roundUp);

  // a carry out leaves 10.000... so only the exponent moves up
  assign rndE = normE + $signed({{expW{1'b0}}, sigRnd[fmtNF+1]});

  ////////////////////
  // range check and pack
  ////////////////////
  always_comb begin
    if (sumZero) begin
      // exact cancellation and all-zero inputs both give +0
      res.word = '0;
    end else if (rndE < 1) begin
      res.word = {sum.ss, {(fmtW-1){1'b0}}};
    end else if (rndE > fmtEMax) begin
      res.word = {sum.ss, {fmtNE{1'b1}}, {fmtNF{1'b0}}};
    end else begin
      res.word = {sum.ss, rndE[fmtNE-1:0], sigRnd[fmtNF-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== fmaUnit.sv ====
// three-cycle binary16 FMA with stream handshake; see fmaMulAlign and fmaNormRound for numeric limits
`timescale 1ns/1ps
`default_nettype none

module fmaUnit import fmaPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       inValid,
  output logic       inReady,
  input  fmaOperandT inOp,
  output logic       outValid,
  input  logic       outReady,
  output fmaResultT  outRes
);

  fmaAlignT  alignD;
  fmaAlignT  alignQ;
  fmaSumT    sumD;
  fmaSumT    sumQ;
  fmaResultT resD;
  logic      alignValid;
  logic      alignReady;
  logic      sumValid;
  logic      sumReady;

  ////////////////////
  // stage 1
  ////////////////////
  fmaMulAlign mulAlign_i (.op(inOp), .align(alignD));

  fmaStageReg #(.payloadT(fmaAlignT)) alignReg_i (
    .clk, .rstN,
    .inValid, .inReady, .inData(alignD),
    .outValid(alignValid), .outReady(alignReady), .outData(alignQ)
  );

  ////////////////////
  // stage 2
  ////////////////////
  fmaSigAdd sigAdd_i (.align(alignQ), .sum(sumD));

  fmaStageReg #(.payloadT(fmaSumT)) sumReg_i (
    .clk, .rstN,
    .inValid(alignValid), .inReady(alignReady), .inData(sumD),
    .outValid(sumValid), .outReady(sumReady), .outData(sumQ)
  );

  ////////////////////
  // stage 3
  ////////////////////
  fmaNormRound normRound_i (.sum(sumQ), .res(resD));

  // last register faces the consumer directly
  fmaStageReg #(.payloadT(fmaResultT)) resReg_i (
    .clk, .rstN,
    .inValid(sumValid), .inReady(sumReady), .inData(resD),
    .outValid, .outReady, .outData(outRes)
  );

endmodule

`default_nettype wire

// ==== fmaUnitTb.sv ====
// directed testbench for fmaUnit with exact binary16 expected words and seeded random stalls
`timescale 1ns/1ps
`default_nettype none

module fmaUnitTb import fmaPkg::*; ();

  localparam int clkPeriod = 4;
  localparam int resetCycles = 5;
  localparam int burstLen = 20;
  localparam int streamLen = 8;
  // items over the whole run set the watchdog budget
  localparam int numItems = 2 + 3 + 2 + 4 + burstLen + streamLen;

  logic       clk = 1'b0;
  logic       rstN;
  logic       inValid;
  logic       inReady;
  fmaOperandT inOp;
  logic       outValid;
  logic       outReady = 1'b1;
  fmaResultT  outRes;

  // scoreboard state
  logic [15:0] expQ[$];
  int          acceptQ[$];
  int          outCycleQ[$];
  int          cycle = 0;
  int          inFlight = 0;
  logic        stallMode = 1'b0;
  logic        latencyMode = 1'b0;
  logic [63:0] stallPat;

  fmaUnit dut_i (.clk, .rstN, .inValid, .inReady, .inOp, .outValid, .outReady, .outRes);

  always #(clkPeriod/2) clk = ~clk;

  // edge count that is read at the same edge it advances on
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // consumer stalls at random only when asked for
  always @(negedge clk) begin
    outReady <= stallMode ? stallPat[cycle[5:0]] : 1'b1;
  end

  task automatic valueMismatch(input string msg);
    $display("[FAIL] time %0d ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic protocolError(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopping on a handshake error");
  endtask

  // small integers only since magnitudes below 2048 stay exact
  function automatic logic [15:0] encodeInt(input int v);
    int   mag;
    int   e;
    logic s;
    s = (v < 0);
    mag = s ? -v : v;
    if (mag == 0) begin
      return 16'h0000;
    end
    e = 0;
    while ((mag >> (e + 1)) != 0) begin
      e++;
    end
    return {s, 5'(e + 15), 10'((mag << (10 - e)) & 32'h3ff)};
  endfunction

  ////////////////////
  // drivers
  ////////////////////
  // one request held until the input transfer
  task automatic sendOp(input logic [15:0] x, input logic [15:0] y, input logic [15:0] z,
                        input logic [15:0] expWord);
    @(negedge clk);
    inValid = 1'b1;
    inOp = {x, y, z};
    expQ.push_back(expWord);
    do begin
      @(posedge clk);
    end while (!inReady);
    acceptQ.push_back(cycle);
  endtask

  task automatic drainPipe();
    @(negedge clk);
    inValid = 1'b0;
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // every output transfer against the head of the queue
  always @(posedge clk) begin : scoreboard
    logic [15:0] expWord;
    int          accepted;
    if (outValid && outReady) begin
      assert (expQ.size() != 0)
        else protocolError("output transfer arrived with no request outstanding");
      expWord = expQ.pop_front();
      accepted = acceptQ.pop_front();
      assert (outRes.word == expWord)
        else valueMismatch($sformatf("result %h, expected %h", outRes.word, expWord));
      if (latencyMode) begin
        assert (cycle == accepted + 3)
          else valueMismatch($sformatf("latency %0d cycles, expected 3", cycle - accepted));
        outCycleQ.push_back(cycle);
      end
    end
  end

  // each register holds one item, so input is refused only with all three full and a stall
  always @(posedge clk) begin : readyModel
    if (rstN) begin
      assert (inReady == (inFlight < 3 || outReady))
        else valueMismatch($sformatf("inReady %b with %0d items in flight",
                                     inReady, inFlight));
      inFlight = inFlight + int'(inValid && inReady) - int'(outValid && outReady);
    end
  end

  ////////////////////
  // directed tests
  ////////////////////
  task automatic exactArith();
    sendOp(16'h4000, 16'h4200, 16'h3c00, 16'h4700);  // 2*3+1 = 7
    sendOp(16'h3e00, 16'h3e00, 16'h3a00, 16'h4200);  // 1.5*1.5+0.75 = 3
    drainPipe();
  endtask

  task automatic subtractCancel();
    sendOp(16'h4200, 16'h4000, 16'hc500, 16'h3c00);  // 3*2-5 = 1
    sendOp(16'h3c00, 16'h4000, 16'hc600, 16'hc400);  // 1*2-6 = -4 through the negated sum
    sendOp(16'h4000, 16'h4000, 16'hc400, 16'h0000);  // 2*2-4 = +0
    drainPipe();
  endtask

  // 2^-12 * 2^-12 is far below half an ulp of 1024
  task automatic killedProduct();
    sendOp(16'h0c00, 16'h0c00, 16'h6400, 16'h6400);
    sendOp(16'h0c00, 16'h0c00, 16'he400, 16'he400);
    drainPipe();
  endtask

  task automatic roundAndRange();
    // 1.5*(1+2^-10) + 2^-10 sits halfway between frac 0x202 and 0x203
    sendOp(16'h3e00, 16'h3c01, 16'h1400, 16'h3e02);
    // without the addend the tie is between 0x201 and 0x202
    sendOp(16'h3e00, 16'h3c01, 16'h0000, 16'h3e02);
    sendOp(16'h5c00, 16'h6000, 16'h0000, 16'h7c00);  // 256*512 overflows
    sendOp(16'h9c00, 16'h1c00, 16'h0000, 16'h8000);  // -2^-16 flushes to -0
    drainPipe();
  endtask

  task automatic backPressure();
    int zVal;
    stallMode = 1'b1;
    for (int k = 0; k < burstLen; k++) begin
      // odd items subtract
      zVal = (k % 2 == 1) ? -k : k;
      sendOp(encodeInt(k + 1), encodeInt(3), encodeInt(zVal), encodeInt(3 * (k + 1) + zVal));
    end
    drainPipe();
    stallMode = 1'b0;
  endtask

  // outReady held high gives one result per cycle
  task automatic throughput();
    latencyMode = 1'b1;
    outCycleQ.delete();
    for (int k = 0; k < streamLen; k++) begin
      sendOp(encodeInt(k + 2), encodeInt(k + 2), encodeInt(-k),
             encodeInt((k + 2) * (k + 2) - k));
    end
    drainPipe();
    latencyMode = 1'b0;
    for (int k = 1; k < outCycleQ.size(); k++) begin
      assert (outCycleQ[k] == outCycleQ[k-1] + 1)
        else valueMismatch($sformatf("gap of %0d cycles between results",
                                     outCycleQ[k] - outCycleQ[k-1]));
    end
  endtask

  initial begin
    void'($urandom(32'hefb5));
    stallPat = {$urandom(), $urandom()};
    rstN = 1'b0;
    inValid = 1'b0;
    inOp = '0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    exactArith();
    subtractCancel();
    killedProduct();
    roundAndRange();
    backPressure();
    throughput();
    // idle cycles let a duplicated or stray result reach the scoreboard
    repeat (8) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

  // 200 cycles per item plus reset
  initial begin
    #((numItems * 200 + resetCycles) * clkPeriod);
    $display("watchdog expired with %0d results still outstanding", expQ.size());
    $display("tests failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== fmaUnit.f ====
fmaPkg.sv
fmaStageReg.sv
fmaMulAlign.sv
fmaSigAdd.sv
fmaNormRound.sv
fmaUnit.sv
fmaUnitTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build fmaUnitTb with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module fmaUnitTb -f fmaUnit.f -Mdir obj_dir
	@out=$$(./obj_dir/VfmaUnitTb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
